//--- Makefile
VERILATOR ?= verilator
TOP       ?= exec_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f compile.f

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- alu/alu_core.sv
`timescale 1ns/1ps

`include "exec_defs.svh"

module alu_core
(
    exec_if.alu                 i_ins,
    output exec_pkg::word_t     o_result,
    output exec_pkg::word_t     o_addr,
    output logic                o_pc_select,
    output exec_pkg::word_t     o_pc_target,
    output exec_pkg::word_t     o_wdata,
    output exec_pkg::byte_sel_t o_wsel
);
    import exec_pkg::*;

    logic              is_cmp;
    logic              carry_in;
    word_t             op_b;
    logic [`XLEN:0]    sum;
    logic              negative;
    logic              overflow;
    logic              eq, lts, ltu;
    logic [4:0]        shamt;
    word_t             shr;
    word_t             alu_res;
    logic              cond;

    // ####################################################################
    // Shared adder for add, sub and all compares
    // ####################################################################

    assign is_cmp   = (i_ins.funct3 == 3'b010) || (i_ins.funct3 == 3'b011);
    assign carry_in = ~i_ins.store &
                      (i_ins.branch | is_cmp | (i_ins.alt & (i_ins.funct3 == 3'b000)));

    assign op_b     = carry_in ? ~i_ins.op2 : i_ins.op2;
    assign sum      = {1'b0, i_ins.op1} + {1'b0, op_b} + {{`XLEN{1'b0}}, carry_in};

    assign negative = sum[`XLEN-1];
    assign overflow = (i_ins.op1[`XLEN-1] == op_b[`XLEN-1]) &
                      (sum[`XLEN-1] != i_ins.op1[`XLEN-1]);

    assign eq  = (sum[`XLEN-1:0] == '0);
    assign lts = negative ^ overflow;
    assign ltu = ~sum[`XLEN];           // No carry out means borrow

    assign shamt = i_ins.op2[4:0];
    assign shr   = i_ins.alt ? word_t'($signed(i_ins.op1) >>> shamt) : (i_ins.op1 >> shamt);

    always_comb
    begin
        case (i_ins.funct3)
            3'b000:  alu_res = sum[`XLEN-1:0];
            3'b001:  alu_res = i_ins.op1 << shamt;
            3'b010:  alu_res = {{(`XLEN-1){1'b0}}, lts};
            3'b011:  alu_res = {{(`XLEN-1){1'b0}}, ltu};
            3'b100:  alu_res = i_ins.op1 ^ i_ins.op2;
            3'b101:  alu_res = shr;
            3'b110:  alu_res = i_ins.op1 | i_ins.op2;
            default: alu_res = i_ins.op1 & i_ins.op2;
        endcase
    end

    assign o_result = i_ins.store ? sum[`XLEN-1:0] : alu_res;
    assign o_addr   = sum[`XLEN-1:0];

    // ####################################################################
    // Branch resolution
    // ####################################################################

    always_comb
    begin
        case (i_ins.funct3[2:1])
            2'b00:   cond = eq;
            2'b10:   cond = lts;
            default: cond = ltu;
        endcase
        cond = cond ^ i_ins.funct3[0];      // BNE, BGE, BGEU
    end

    assign o_pc_select = i_ins.jump | (i_ins.branch & cond);
    assign o_pc_target = i_ins.pc_target;

    // ####################################################################
    // Store lanes
    // ####################################################################

    always_comb
    begin
        case (i_ins.funct3[1:0])
            2'b00:   o_wdata = {4{i_ins.store_data[7:0]}};
            2'b01:   o_wdata = {2{i_ins.store_data[15:0]}};
            default: o_wdata = i_ins.store_data;
        endcase
    end

    always_comb
    begin
        case (i_ins.funct3[1:0])
            2'b00:   o_wsel = byte_sel_t'(4'b0001 << sum[1:0]);
            2'b01:   o_wsel = sum[1] ? 4'b1100 : 4'b0011;
            default: o_wsel = 4'b1111;
        endcase
    end

endmodule

//--- common/exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

`define XLEN        32
`define DIV_STEPS   32

// Unit group codes
`define GRP_ALU     2'd0
`define GRP_MUL     2'd1
`define GRP_DIV     2'd2

`endif

//--- common/exec_if.sv
`timescale 1ns/1ps

interface exec_if;
    import exec_pkg::*;

    logic     valid;
    word_t    op1;
    word_t    op2;
    grp_t     grp;
    funct3_t  funct3;
    logic     alt;          // Sub, sra
    reg_idx_t rd;
    logic     reg_write;
    logic     store;
    word_t    store_data;
    logic     branch;
    logic     jump;
    word_t    pc_target;

    modport issue (output valid, op1, op2, grp, funct3, alt, rd, reg_write,
                   store, store_data, branch, jump, pc_target);

    modport alu (input op1, op2, funct3, alt, store, store_data, branch, jump,
                 pc_target);

    modport md (input op1, op2, funct3);

endinterface

//--- common/exec_pkg.sv
`include "exec_defs.svh"

package exec_pkg;

    // ####################################################################
    // Data words and instruction fields
    // ####################################################################

    typedef logic [`XLEN-1:0] word_t;       // Operand, result, address
    typedef logic [4:0]       reg_idx_t;
    typedef logic [2:0]       funct3_t;
    typedef logic [1:0]       grp_t;        // Unit group
    typedef logic [3:0]       byte_sel_t;   // Store byte enables

    // ####################################################################
    // Divider sequencing
    // ####################################################################

    // Wide enough to hold DIV_STEPS itself
    typedef logic [5:0]       step_cnt_t;

    typedef enum logic [1:0]
    {
        IDLE,
        RUN,
        DONE
    } div_state_t;

endpackage

//--- compile.f
+incdir+common
common/exec_pkg.sv
common/exec_if.sv
design/exec_issue_reg.sv
alu/alu_core.sv
muldiv/div_ctrl.sv
muldiv/div_step_counter.sv
muldiv/muldiv_datapath.sv
design/exec_top.sv
verif/exec_props.sv
verif/exec_tb.sv

//--- design/exec_issue_reg.sv
`timescale 1ns/1ps

module exec_issue_reg
(
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_flush,
    input  logic               i_valid,
    input  logic               i_busy,
    input  exec_pkg::word_t    i_op1,
    input  exec_pkg::word_t    i_op2,
    input  exec_pkg::grp_t     i_grp,
    input  exec_pkg::funct3_t  i_funct3,
    input  logic               i_alt,
    input  exec_pkg::reg_idx_t i_rd,
    input  logic               i_reg_write,
    input  logic               i_store,
    input  exec_pkg::word_t    i_store_data,
    input  logic               i_branch,
    input  logic               i_jump,
    input  exec_pkg::word_t    i_pc_target,
    exec_if.issue              o_ins
);
    import exec_pkg::*;

    logic sample;

    assign sample = i_valid & ~i_busy;

    // Control bits are only set for the cycle after a sample
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_ins.valid     <= 1'b0;
            o_ins.reg_write <= 1'b0;
            o_ins.store     <= 1'b0;
            o_ins.branch    <= 1'b0;
            o_ins.jump      <= 1'b0;
        end
        else if (i_flush)
        begin
            o_ins.valid     <= 1'b0;
            o_ins.reg_write <= 1'b0;
            o_ins.store     <= 1'b0;
            o_ins.branch    <= 1'b0;
            o_ins.jump      <= 1'b0;
        end
        else
        begin
            o_ins.valid     <= sample;
            o_ins.reg_write <= sample & i_reg_write;
            o_ins.store     <= sample & i_store;
            o_ins.branch    <= sample & i_branch;
            o_ins.jump      <= sample & i_jump;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (sample)
        begin
            o_ins.op1        <= i_op1;
            o_ins.op2        <= i_op2;
            o_ins.grp        <= i_grp;
            o_ins.funct3     <= i_funct3;
            o_ins.alt        <= i_alt;
            o_ins.rd         <= i_rd;
            o_ins.store_data <= i_store_data;
            o_ins.pc_target  <= i_pc_target;
        end
    end

endmodule

//--- design/exec_top.sv
`timescale 1ns/1ps

`include "exec_defs.svh"

module exec_top
(
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_flush,
    input  logic                i_valid,
    input  exec_pkg::word_t     i_op1,
    input  exec_pkg::word_t     i_op2,
    input  exec_pkg::grp_t      i_grp,
    input  exec_pkg::funct3_t   i_funct3,
    input  logic                i_alt,
    input  exec_pkg::reg_idx_t  i_rd,
    input  logic                i_reg_write,
    input  logic                i_store,
    input  exec_pkg::word_t     i_store_data,
    input  logic                i_branch,
    input  logic                i_jump,
    input  exec_pkg::word_t     i_pc_target,
    output logic                o_valid,
    output logic                o_busy,
    output exec_pkg::word_t     o_result,
    output exec_pkg::reg_idx_t  o_rd,
    output logic                o_reg_write,
    output logic                o_pc_select,
    output exec_pkg::word_t     o_pc_target,
    output logic                o_store,
    output exec_pkg::word_t     o_addr,
    output exec_pkg::word_t     o_wdata,
    output exec_pkg::byte_sel_t o_wsel
);
    import exec_pkg::*;

    exec_if   ins_if ();

    word_t    alu_res, mul_res, div_res;
    logic     div_start, div_load, div_step, div_last, div_done;
    logic     fast_valid;
    reg_idx_t div_rd_q;
    logic     div_reg_write_q;

    exec_issue_reg issue_reg_i
    (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_flush(i_flush),
        .i_valid(i_valid), .i_busy(o_busy),
        .i_op1(i_op1), .i_op2(i_op2), .i_grp(i_grp), .i_funct3(i_funct3),
        .i_alt(i_alt), .i_rd(i_rd), .i_reg_write(i_reg_write),
        .i_store(i_store), .i_store_data(i_store_data),
        .i_branch(i_branch), .i_jump(i_jump), .i_pc_target(i_pc_target),
        .o_ins(ins_if.issue)
    );

    alu_core alu_core_i
    (
        .i_ins(ins_if.alu), .o_result(alu_res), .o_addr(o_addr),
        .o_pc_select(o_pc_select), .o_pc_target(o_pc_target),
        .o_wdata(o_wdata), .o_wsel(o_wsel)
    );

    // ####################################################################
    // Multiply / divide unit
    // ####################################################################

    assign div_start = ins_if.valid & (ins_if.grp == `GRP_DIV);

    div_ctrl div_ctrl_i
    (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_flush(i_flush),
        .i_start(div_start), .i_last(div_last),
        .o_load(div_load), .o_step(div_step), .o_busy(o_busy), .o_done(div_done)
    );

    div_step_counter div_cnt_i
    (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_load(div_load), .i_step(div_step), .o_last(div_last)
    );

    muldiv_datapath muldiv_i
    (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_ins(ins_if.md),
        .i_load(div_load), .i_step(div_step),
        .o_mul_res(mul_res), .o_div_res(div_res)
    );

    // Destination of the division in flight
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            div_reg_write_q <= 1'b0;
        else if (div_load)
            div_reg_write_q <= ins_if.reg_write;
    end

    always_ff @(posedge i_clk)
    begin
        if (div_load)
            div_rd_q <= ins_if.rd;
    end

    // ####################################################################
    // Result merge
    // ####################################################################

    assign fast_valid = ins_if.valid &
                        ((ins_if.grp == `GRP_ALU) | (ins_if.grp == `GRP_MUL));

    always_comb
    begin
        if (div_done)
            o_result = div_res;
        else if (ins_if.grp == `GRP_MUL)
            o_result = mul_res;
        else
            o_result = alu_res;
    end

    assign o_valid     = fast_valid | div_done;
    assign o_rd        = div_done ? div_rd_q : ins_if.rd;
    assign o_reg_write = div_done ? div_reg_write_q : (fast_valid & ins_if.reg_write);
    assign o_store     = ins_if.store;

endmodule

//--- muldiv/div_ctrl.sv
`timescale 1ns/1ps

module div_ctrl
(
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_flush,
    input  logic i_start,
    input  logic i_last,
    output logic o_load,
    output logic o_step,
    output logic o_busy,
    output logic o_done
);
    import exec_pkg::*;

    div_state_t state_q;
    div_state_t state_d;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
            begin
                if (i_start)
                    state_d = RUN;
            end
            RUN:
            begin
                if (i_last)
                    state_d = DONE;
            end
            default: state_d = IDLE;    // Result shown for one cycle
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            state_q <= IDLE;
        else if (i_flush)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    assign o_load = (state_q == IDLE) & i_start;
    assign o_step = (state_q == RUN);
    assign o_done = (state_q == DONE);

    // Busy already in the start cycle so the next issue is held off
    assign o_busy = o_load | o_step;

endmodule

//--- muldiv/div_step_counter.sv
`timescale 1ns/1ps

`include "exec_defs.svh"

module div_step_counter
(
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_load,
    input  logic i_step,
    output logic o_last
);
    import exec_pkg::*;

    step_cnt_t cnt_q;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            cnt_q <= '0;
        else if (i_load)
            cnt_q <= step_cnt_t'(`DIV_STEPS);
        else if (i_step)
            cnt_q <= cnt_q - step_cnt_t'(1);
    end

    assign o_last = i_step & (cnt_q == step_cnt_t'(1));   // Final step

endmodule

//--- muldiv/muldiv_datapath.sv
`timescale 1ns/1ps

`include "exec_defs.svh"

module muldiv_datapath
(
    input  logic            i_clk,
    input  logic            i_arst_n,
    exec_if.md              i_ins,
    input  logic            i_load,
    input  logic            i_step,
    output exec_pkg::word_t o_mul_res,
    output exec_pkg::word_t o_div_res
);
    import exec_pkg::*;

    // ####################################################################
    // Multiply
    // ####################################################################

    logic                       a_signed, b_signed;
    logic signed [`XLEN:0]      ma, mb;
    logic signed [2*`XLEN+1:0]  prod;

    assign a_signed = (i_ins.funct3[1:0] == 2'b01) | (i_ins.funct3[1:0] == 2'b10);
    assign b_signed = (i_ins.funct3[1:0] == 2'b01);

    assign ma   = $signed({a_signed & i_ins.op1[`XLEN-1], i_ins.op1});
    assign mb   = $signed({b_signed & i_ins.op2[`XLEN-1], i_ins.op2});
    assign prod = ma * mb;

    assign o_mul_res = (i_ins.funct3[1:0] == 2'b00) ? prod[`XLEN-1:0] : prod[2*`XLEN-1:`XLEN];

    // ####################################################################
    // Restoring divide
    // ####################################################################

    logic           div_signed;
    word_t          mag1, mag2;
    logic           neg_q, neg_r, rem_sel, div_zero;
    word_t          quo_q, rem_q, dvsr_q;
    logic [`XLEN:0] shifted;
    logic [`XLEN:0] diff;
    word_t          quo_fin, rem_fin;

    assign div_signed = ~i_ins.funct3[0];
    assign mag1 = (div_signed & i_ins.op1[`XLEN-1]) ? -i_ins.op1 : i_ins.op1;
    assign mag2 = (div_signed & i_ins.op2[`XLEN-1]) ? -i_ins.op2 : i_ins.op2;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            neg_q    <= 1'b0;
            neg_r    <= 1'b0;
            rem_sel  <= 1'b0;
            div_zero <= 1'b0;
        end
        else if (i_load)
        begin
            neg_q    <= div_signed & (i_ins.op1[`XLEN-1] ^ i_ins.op2[`XLEN-1]);
            neg_r    <= div_signed & i_ins.op1[`XLEN-1];
            rem_sel  <= i_ins.funct3[1];
            div_zero <= (i_ins.op2 == '0);
        end
    end

    assign shifted = {rem_q, quo_q[`XLEN-1]};
    assign diff    = shifted - {1'b0, dvsr_q};

    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            quo_q  <= mag1;
            rem_q  <= '0;
            dvsr_q <= mag2;
        end
        else if (i_step)
        begin
            if (!diff[`XLEN])       // Trial subtract fits
            begin
                rem_q <= diff[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b1};
            end
            else
            begin
                rem_q <= shifted[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b0};
            end
        end
    end

    // Zero divisor leaves the dividend in the remainder on its own
    assign quo_fin   = div_zero ? '1 : (neg_q ? -quo_q : quo_q);
    assign rem_fin   = neg_r ? -rem_q : rem_q;
    assign o_div_res = rem_sel ? rem_fin : quo_fin;

endmodule

//--- verif/exec_props.sv
`timescale 1ns/1ps

`include "exec_defs.svh"

module exec_props
(
    input logic               i_clk,
    input logic               i_arst_n,
    input logic               i_flush,
    input logic               i_valid,
    input exec_pkg::grp_t     i_grp,
    input logic               i_busy,
    input logic               i_out_valid
);
    localparam int BUSY_CYCLES = `DIV_STEPS + 1;

    logic sampled_div;

    // Division accepted by the issue register at this edge
    assign sampled_div = i_valid & ~i_busy & ~i_flush & (i_grp == `GRP_DIV);

    // ####################################################################
    // Reset and flush
    // ####################################################################

    quiet_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !i_out_valid)
        else $error("o_valid high while reset is asserted");

    flush_kills_result: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_flush |=> !i_out_valid)
        else $error("o_valid in the cycle after a flush");

    flush_drops_busy: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_flush |=> !i_busy)
        else $error("o_busy still high after a flush");

    // ####################################################################
    // Divider timing
    // ####################################################################

    // Aborted by a flush anywhere in the window
    div_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n || i_flush)
        sampled_div |=> i_busy [*BUSY_CYCLES] ##1 (i_out_valid && !i_busy))
        else $error("division busy window or result cycle is wrong");

    busy_needs_div: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $rose(i_busy) |-> $past(sampled_div))
        else $error("o_busy rose without an accepted division");

endmodule

//--- verif/exec_tb.sv
`timescale 1ns/1ps

`include "exec_defs.svh"

module exec_tb;
    import exec_pkg::*;

    localparam int NUM_TESTS = 150;

    logic      i_clk = 1'b0;
    logic      i_arst_n;
    logic      i_flush;
    logic      i_valid;
    word_t     i_op1;
    word_t     i_op2;
    grp_t      i_grp;
    funct3_t   i_funct3;
    logic      i_alt;
    reg_idx_t  i_rd;
    logic      i_reg_write;
    logic      i_store;
    word_t     i_store_data;
    logic      i_branch;
    logic      i_jump;
    word_t     i_pc_target;
    logic      o_valid;
    logic      o_busy;
    word_t     o_result;
    reg_idx_t  o_rd;
    logic      o_reg_write;
    logic      o_pc_select;
    word_t     o_pc_target;
    logic      o_store;
    word_t     o_addr;
    word_t     o_wdata;
    byte_sel_t o_wsel;

    int        cyc = 0;
    word_t     corners[6];

    // Expected results, oldest first
    int        q_due[$];
    int        q_kind[$];           // 0 result, 1 branch or jump, 2 store
    word_t     q_res[$];
    reg_idx_t  q_rd[$];
    logic      q_wr[$];
    logic      q_pcsel[$];
    word_t     q_tgt[$];
    word_t     q_wdata[$];
    byte_sel_t q_wsel[$];

    exec_top exec_top_i (.*);

    bind exec_top exec_props props_i
    (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_flush(i_flush), .i_valid(i_valid),
        .i_grp(i_grp), .i_busy(o_busy), .i_out_valid(o_valid)
    );

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk)
        cyc <= cyc + 1;

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // ####################################################################
    // Reference model
    // ####################################################################

    function automatic word_t alu_model(funct3_t f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(funct3_t f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t mul_model(funct3_t f3, word_t a, word_t b);
        logic        sa;
        logic        sb;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        case (f3[1:0])
            2'b01:   {sa, sb} = 2'b11;  // MULH
            2'b10:   {sa, sb} = 2'b10;  // MULHSU
            default: {sa, sb} = 2'b00;  // MUL and MULHU
        endcase
        ea = {{32{sa & a[31]}}, a};
        eb = {{32{sb & b[31]}}, b};
        p  = ea * eb;                   // Low 64 bits exact for any sign mix
        return (f3[1:0] == 2'b00) ? p[31:0] : p[63:32];
    endfunction

    function automatic word_t div_model(funct3_t f3, word_t a, word_t b);
        if (b == 32'd0)
            return f3[1] ? a : 32'hFFFF_FFFF;
        if (!f3[0] && a == 32'h8000_0000 && b == 32'hFFFF_FFFF)
            return f3[1] ? 32'd0 : a;
        if (!f3[0])
            return f3[1] ? word_t'($signed(a) % $signed(b)) : word_t'($signed(a) / $signed(b));
        return f3[1] ? a % b : a / b;
    endfunction

    // Each lane repeats the stored unit
    function automatic word_t store_lanes(funct3_t f3, word_t d);
        int    nbytes;
        word_t w;
        nbytes = 1 << f3[1:0];
        for (int i = 0; i < 4; i++)
            w[8*i +: 8] = d[8*(i % nbytes) +: 8];
        return w;
    endfunction

    // Lanes of the aligned group that holds the address
    function automatic byte_sel_t store_enables(funct3_t f3, word_t addr);
        int        nbytes;
        byte_sel_t sel;
        nbytes = 1 << f3[1:0];
        for (int i = 0; i < 4; i++)
            sel[i] = ((i / nbytes) == (int'(addr[1:0]) / nbytes));
        return sel;
    endfunction

    function automatic word_t pick_operand();
        if ($urandom_range(3) == 0)
            return corners[$urandom_range(5)];
        return $urandom;
    endfunction

    // ####################################################################
    // Stimulus
    // ####################################################################

    task automatic wait_drain();
        while (q_due.size() != 0)
            @(negedge i_clk);
    endtask

    task automatic idle();
        @(negedge i_clk);
        i_valid = 1'b0;
    endtask

    task automatic send(input grp_t g, input funct3_t f3, input logic alt, input word_t a,
                        input word_t b, input logic st, input logic br, input logic jp,
                        input logic keep);
        reg_idx_t rd;
        word_t    sdata;
        word_t    tgt;
        word_t    res;
        rd    = reg_idx_t'($urandom);
        sdata = $urandom;
        tgt   = $urandom;
        if (g == `GRP_MUL)
            res = mul_model(f3, a, b);
        else if (g == `GRP_DIV)
            res = div_model(f3, a, b);
        else
            res = st ? a + b : alu_model(f3, alt, a, b);
        @(negedge i_clk);
        i_valid      = 1'b1;
        i_grp        = g;
        i_funct3     = f3;
        i_alt        = alt;
        i_op1        = a;
        i_op2        = b;
        i_rd         = rd;
        i_reg_write  = !st && !br;
        i_store      = st;
        i_store_data = sdata;
        i_branch     = br;
        i_jump       = jp;
        i_pc_target  = tgt;
        if (keep)
        begin
            q_due.push_back(cyc + ((g == `GRP_DIV) ? `DIV_STEPS + 2 : 1));
            q_kind.push_back((br || jp) ? 1 : (st ? 2 : 0));
            q_res.push_back(res);
            q_rd.push_back(rd);
            q_wr.push_back(!st && !br);
            q_pcsel.push_back(jp || (br && branch_taken(f3, a, b)));
            q_tgt.push_back(tgt);
            q_wdata.push_back(store_lanes(f3, sdata));
            q_wsel.push_back(store_enables(f3, a + b));
        end
        if (g == `GRP_DIV)
        begin
            idle();
            if (keep)
                wait_drain();   // Source holds off while busy
        end
    endtask

    // ####################################################################
    // Output checks
    // ####################################################################

    task automatic check_output();
        int        due;
        int        kind;
        word_t     res;
        word_t     tgt;
        word_t     wdata;
        byte_sel_t wsel;
        reg_idx_t  rd;
        logic      wr;
        logic      pcsel;
        due   = q_due.pop_front();
        kind  = q_kind.pop_front();
        res   = q_res.pop_front();
        rd    = q_rd.pop_front();
        wr    = q_wr.pop_front();
        pcsel = q_pcsel.pop_front();
        tgt   = q_tgt.pop_front();
        wdata = q_wdata.pop_front();
        wsel  = q_wsel.pop_front();
        assert (cyc == due) else fail_now($sformatf(
            "mismatch at %0t: o_valid in cycle %0d, expected cycle %0d", $time, cyc, due));
        assert (o_rd == rd && o_reg_write == wr) else fail_now($sformatf(
            "mismatch at %0t: rd %0d/%0b, expected %0d/%0b", $time, o_rd, o_reg_write, rd, wr));
        if (kind == 1)
            assert (o_pc_select == pcsel && o_pc_target == tgt) else fail_now($sformatf(
                "mismatch at %0t: pc_select %0b target %h, expected %0b %h",
                $time, o_pc_select, o_pc_target, pcsel, tgt));
        else
            assert (o_result == res) else fail_now($sformatf(
                "mismatch at %0t: result %h, expected %h", $time, o_result, res));
        if (kind == 2)
            assert (o_store && o_addr == res && o_wdata == wdata && o_wsel == wsel)
                else fail_now($sformatf("mismatch at %0t: store %h %h %b, expected %h %h %b",
                    $time, o_addr, o_wdata, o_wsel, res, wdata, wsel));
    endtask

    always @(negedge i_clk)
    begin
        if (i_arst_n === 1'b1 && o_valid)
        begin
            if (q_due.size() == 0)
                fail_now($sformatf("Unexpected o_valid at %0t with nothing pending", $time));
            else
                check_output();
        end
    end

    initial
    begin
        #((NUM_TESTS * 40 + 200) * 10);
        fail_now("Timeout: the run did not finish in time");
    end

    initial
    begin
        word_t a;
        void'($urandom(32'h6fef));
        corners[0]   = 32'h0000_0000;
        corners[1]   = 32'h0000_0001;
        corners[2]   = 32'hFFFF_FFFF;
        corners[3]   = 32'h8000_0000;
        corners[4]   = 32'h7FFF_FFFF;
        corners[5]   = 32'hFFFF_FFFE;
        i_arst_n     = 1'b0;
        i_flush      = 1'b0;
        i_valid      = 1'b0;
        i_op1        = '0;
        i_op2        = '0;
        i_grp        = `GRP_ALU;
        i_funct3     = '0;
        i_alt        = 1'b0;
        i_rd         = '0;
        i_reg_write  = 1'b0;
        i_store      = 1'b0;
        i_store_data = '0;
        i_branch     = 1'b0;
        i_jump       = 1'b0;
        i_pc_target  = '0;
        repeat (2) @(posedge i_clk);
        assert (!o_valid && !o_busy && !o_pc_select && !o_store && !o_reg_write)
            else fail_now("Control outputs are not cleared by reset");
        @(negedge i_clk);
        i_arst_n = 1'b1;

        for (int rep = 0; rep < 4; rep++)       // Back-to-back ALU ops
            for (int f = 0; f < 8; f++)
                for (int alt = 0; alt < 2; alt++)
                    send(`GRP_ALU, funct3_t'(f), alt[0], pick_operand(), pick_operand(),
                         1'b0, 1'b0, 1'b0, 1'b1);
        for (int f = 0; f < 8; f++)
        begin
            if (f != 2 && f != 3)
            begin
                a = pick_operand();
                send(`GRP_ALU, funct3_t'(f), 1'b0, a, a, 1'b0, 1'b1, 1'b0, 1'b1);
                send(`GRP_ALU, funct3_t'(f), 1'b0, a, pick_operand(), 1'b0, 1'b1, 1'b0, 1'b1);
            end
        end
        send(`GRP_ALU, 3'b000, 1'b0, $urandom, $urandom, 1'b0, 1'b0, 1'b1, 1'b1);
        send(`GRP_ALU, 3'b000, 1'b0, $urandom, $urandom, 1'b0, 1'b1, 1'b1, 1'b1);
        for (int sz = 0; sz < 3; sz++)
            for (int al = 0; al < 4; al++)
                send(`GRP_ALU, funct3_t'(sz), 1'b0, $urandom & 32'hFFFF_FFFC, word_t'(al),
                     1'b1, 1'b0, 1'b0, 1'b1);
        for (int f = 0; f < 4; f++)
            for (int i = 0; i < 8; i++)
                send(`GRP_MUL, funct3_t'(f), 1'b0, (i < 6) ? corners[i] : pick_operand(),
                     (i < 6) ? corners[5 - i] : pick_operand(), 1'b0, 1'b0, 1'b0, 1'b1);
        for (int f = 4; f < 8; f++)
        begin
            for (int i = 0; i < 4; i++)
                send(`GRP_DIV, funct3_t'(f), 1'b0, pick_operand(), $urandom >> (i * 8),
                     1'b0, 1'b0, 1'b0, 1'b1);
            send(`GRP_DIV, funct3_t'(f), 1'b0, $urandom, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
            send(`GRP_DIV, funct3_t'(f), 1'b0, 32'h8000_0000, 32'hFFFF_FFFF,
                 1'b0, 1'b0, 1'b0, 1'b1);
        end

        // Flush alongside an ALU op, then during a division
        idle();
        wait_drain();
        send(`GRP_ALU, 3'b000, 1'b0, $urandom, $urandom, 1'b0, 1'b0, 1'b0, 1'b0);
        i_flush = 1'b1;
        idle();
        i_flush = 1'b0;
        send(`GRP_DIV, 3'b100, 1'b0, $urandom, $urandom, 1'b0, 1'b0, 1'b0, 1'b0);
        repeat (10) @(negedge i_clk);
        i_flush = 1'b1;
        @(negedge i_clk);
        i_flush = 1'b0;
        assert (!o_busy) else fail_now("o_busy still high after a flush");
        repeat (40) @(negedge i_clk);

        if (q_due.size() == 0)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
            fail_now("Results were still pending at the end of the run");
    end

endmodule
